/* hw/pt2272_pkg.sv */
`default_nettype none

package pt2272_pkg;

    localparam int NUM_ADDR = 8;                    // Address trits A0..A7
    localparam int NUM_DATA = 4;                    // Data bits D0..D3
    localparam int NUM_SYMS = NUM_ADDR + NUM_DATA;  // Code bits per frame

    // Two-bit code per PT2272 bit, also used for the address pins
    typedef enum logic [1:0] {
        SYM_0    = 2'b00,
        SYM_SYNC = 2'b01,
        SYM_F    = 2'b10,
        SYM_1    = 2'b11
    } sym_code_t;

    typedef struct packed {
        logic [9:0] high_len;  // High phase in ticks
        logic [9:0] low_len;   // Low phase in ticks, saturates
        logic       valid;
    } pulse_t;

    typedef struct packed {
        sym_code_t code;
        logic      valid;  // Good code bit or sync
        logic      bad;    // Malformed pulse sequence
    } symbol_t;

    // Same 24 bits, first transmitted symbol in the top two bits
    typedef union packed {
        sym_code_t [0:NUM_SYMS-1] syms;  // Shift view
        struct packed {
            sym_code_t [0:NUM_ADDR-1] addr;  // Trit 0 first
            sym_code_t [0:NUM_DATA-1] data;  // Data bit 0 first
        } fields;                            // Decode view
    } frame_u;

    typedef struct packed {
        frame_u word;
        logic   valid;  // Complete 12-bit frame
        logic   abort;  // Broken frame
    } frame_t;

endpackage

`default_nettype wire

/* hw/osc_tick_gen.sv */
`default_nettype none

module osc_tick_gen #(
    parameter int TICK_DIV = 250
) (
    input  logic osc_clk,
    input  logic reset,
    output logic tick_o
);

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CW-1:0] div_cnt;  // Counts down to zero

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else begin
            if (div_cnt == '0)
                div_cnt <= CW'(TICK_DIV - 1);  // Reload
            else
                div_cnt <= div_cnt - 1'b1;
            tick_o <= (div_cnt == '0);  // One cycle per period
        end
    end

    a_tick_spacing: assert property (@(posedge osc_clk) disable iff (reset)
        (tick_o && TICK_DIV > 1) |=> !tick_o)
        else $error("osc_tick_gen: back to back ticks");

endmodule

`default_nettype wire

/* hw/pulse_meter.sv */
`default_nettype none

module pulse_meter #(
    parameter int ALPHA_TICKS = 4
) (
    input  logic               osc_clk,
    input  logic               reset,
    input  logic               tick_i,
    input  logic               cod_i,
    output pt2272_pkg::pulse_t pulse_o
);

    import pt2272_pkg::*;

    // Longest sync is 124 alpha, leave some room above it
    localparam int LEN_CAP = (128 * ALPHA_TICKS - 1 > 1023) ? 1023 : 128 * ALPHA_TICKS - 1;
    localparam logic [9:0] LEN_MAX = 10'(LEN_CAP);

    logic [1:0] sync_q;    // Two-flop synchroniser
    logic       line_q;    // Level at previous tick
    logic       rise;
    logic       started;   // First rising edge seen
    logic [9:0] high_cnt;
    logic [9:0] low_cnt;

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset)
            sync_q <= 2'b00;
        else
            sync_q <= {sync_q[0], cod_i};
    end

    assign rise = tick_i && sync_q[1] && !line_q;  // Edges only count on ticks

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            line_q   <= 1'b0;
            started  <= 1'b0;
            high_cnt <= '0;
            low_cnt  <= '0;
        end else if (tick_i) begin
            line_q <= sync_q[1];
            if (rise) begin
                started  <= 1'b1;
                high_cnt <= 10'd1;  // This tick is already high
                low_cnt  <= '0;
            end else if (sync_q[1]) begin
                if (high_cnt != LEN_MAX)
                    high_cnt <= high_cnt + 10'd1;
            end else if (low_cnt != LEN_MAX) begin
                low_cnt <= low_cnt + 10'd1;  // Saturates on long sync gaps
            end
        end
    end

    // Publish the finished high/low pair when the next pulse begins
    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            pulse_o <= '0;
        end else begin
            pulse_o.valid <= rise && started;
            if (rise) begin
                pulse_o.high_len <= high_cnt;
                pulse_o.low_len  <= low_cnt;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/symbol_classifier.sv */
`default_nettype none

module symbol_classifier #(
    parameter int ALPHA_TICKS = 4
) (
    input  logic                osc_clk,
    input  logic                reset,
    input  pt2272_pkg::pulse_t  pulse_i,
    output pt2272_pkg::symbol_t sym_o
);

    import pt2272_pkg::*;

    localparam int WIDE_MIN  = 8 * ALPHA_TICKS;   // Wide high phase
    localparam int SYNC_MIN  = 64 * ALPHA_TICKS;  // Sync gap
    localparam int SHORT_MIN = 2 * ALPHA_TICKS;   // Below this is a glitch

    logic wide_hi;
    logic sync_lo;
    logic short_ph;
    logic half_open;  // First pulse of a bit held
    logic half_wide;  // Width of that first pulse

    assign wide_hi  = (pulse_i.high_len >= WIDE_MIN);
    assign sync_lo  = (pulse_i.low_len >= SYNC_MIN);
    assign short_ph = (pulse_i.high_len < SHORT_MIN) || (pulse_i.low_len < SHORT_MIN);

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            sym_o     <= '0;
            half_open <= 1'b0;
            half_wide <= 1'b0;
        end else begin
            sym_o.valid <= 1'b0;
            sym_o.bad   <= 1'b0;
            if (pulse_i.valid) begin
                if (short_ph) begin
                    sym_o.bad <= 1'b1;
                    half_open <= 1'b0;
                end else if (sync_lo) begin
                    half_open <= 1'b0;
                    if (half_open || wide_hi) begin
                        sym_o.bad <= 1'b1;  // Sync inside a bit, or wide sync pulse
                    end else begin
                        sym_o.valid <= 1'b1;
                        sym_o.code  <= SYM_SYNC;
                    end
                end else if (!half_open) begin
                    half_open <= 1'b1;  // Wait for second pulse
                    half_wide <= wide_hi;
                end else begin
                    half_open <= 1'b0;
                    case ({half_wide, wide_hi})
                        2'b00: begin
                            sym_o.valid <= 1'b1;
                            sym_o.code  <= SYM_0;
                        end
                        2'b11: begin
                            sym_o.valid <= 1'b1;
                            sym_o.code  <= SYM_1;
                        end
                        2'b01: begin
                            sym_o.valid <= 1'b1;
                            sym_o.code  <= SYM_F;
                        end
                        default: sym_o.bad <= 1'b1;  // Wide then narrow
                    endcase
                end
            end
        end
    end

    a_bad_excl: assert property (@(posedge osc_clk) disable iff (reset)
        !(sym_o.valid && sym_o.bad))
        else $error("symbol_classifier: good and bad strobe together");

endmodule

`default_nettype wire

/* hw/frame_assembler.sv */
`default_nettype none

module frame_assembler (
    input  logic                osc_clk,
    input  logic                reset,
    input  pt2272_pkg::symbol_t sym_i,
    output pt2272_pkg::frame_t  frame_o
);

    import pt2272_pkg::*;

    localparam logic [3:0] CNT_FULL = 4'(NUM_SYMS);
    localparam logic [3:0] CNT_OVER = 4'(NUM_SYMS + 1);  // Too many bits

    frame_u     shreg;    // Oldest symbol at syms[0]
    logic [3:0] sym_cnt;
    logic       valid_q;
    logic       abort_q;

    always_ff @(posedge osc_clk) begin
        if (sym_i.valid && sym_i.code != SYM_SYNC) begin
            for (int i = 0; i < NUM_SYMS - 1; i++)
                shreg.syms[i] <= shreg.syms[i+1];
            shreg.syms[NUM_SYMS-1] <= sym_i.code;  // Newest enters at the end
        end
    end

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            sym_cnt <= '0;
            valid_q <= 1'b0;
            abort_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            abort_q <= 1'b0;
            if (sym_i.bad) begin
                abort_q <= 1'b1;
                sym_cnt <= '0;
            end else if (sym_i.valid) begin
                if (sym_i.code == SYM_SYNC) begin
                    valid_q <= (sym_cnt == CNT_FULL);  // Exactly 12 bits
                    abort_q <= (sym_cnt != CNT_FULL);
                    sym_cnt <= '0;
                end else if (sym_cnt != CNT_OVER) begin
                    sym_cnt <= sym_cnt + 4'd1;
                end
            end
        end
    end

    assign frame_o = '{word: shreg, valid: valid_q, abort: abort_q};

    a_close_excl: assert property (@(posedge osc_clk) disable iff (reset)
        !(frame_o.valid && frame_o.abort))
        else $error("frame_assembler: valid and abort together");

endmodule

`default_nettype wire

/* hw/frame_checker.sv */
`default_nettype none

module frame_checker (
    input  logic                                            osc_clk,
    input  logic                                            reset,
    input  pt2272_pkg::frame_t                              frame_i,
    input  pt2272_pkg::sym_code_t [0:pt2272_pkg::NUM_ADDR-1] addr_i,
    output logic [pt2272_pkg::NUM_DATA-1:0]                 data_o,
    output logic                                            dv_o
);

    import pt2272_pkg::*;

    frame_u              hist;       // Previous complete frame
    logic                hist_vld;
    logic                addr_ok;
    logic                data_ok;    // No F in data field
    logic                repeat_ok;
    logic [NUM_DATA-1:0] data_bits;

    always_comb begin
        addr_ok   = (frame_i.word.fields.addr == addr_i);
        repeat_ok = hist_vld && (frame_i.word == hist);
        data_ok   = 1'b1;
        for (int i = 0; i < NUM_DATA; i++) begin
            if (frame_i.word.fields.data[i] != SYM_0 && frame_i.word.fields.data[i] != SYM_1)
                data_ok = 1'b0;
            data_bits[i] = (frame_i.word.fields.data[i] == SYM_1);
        end
    end

    always_ff @(posedge osc_clk) begin
        if (frame_i.valid)
            hist <= frame_i.word;  // Any complete frame, matching or not
    end

    always_ff @(posedge osc_clk or posedge reset) begin
        if (reset) begin
            hist_vld <= 1'b0;
            data_o   <= '0;
            dv_o     <= 1'b0;
        end else begin
            dv_o <= 1'b0;
            if (frame_i.abort) begin
                hist_vld <= 1'b0;  // Broken frame breaks the repeat chain
            end else if (frame_i.valid) begin
                hist_vld <= 1'b1;
                if (addr_ok && data_ok && repeat_ok) begin
                    data_o <= data_bits;
                    dv_o   <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pt2272_decoder.sv */
`default_nettype none

module pt2272_decoder #(
    parameter int TICK_DIV    = 250,  // osc_clk cycles per sample tick
    parameter int ALPHA_TICKS = 4     // Sample ticks per alpha
) (
    input  logic                                            osc_clk,
    input  logic                                            reset,
    input  logic                                            cod_i,
    input  pt2272_pkg::sym_code_t [0:pt2272_pkg::NUM_ADDR-1] A_i,
    output logic [pt2272_pkg::NUM_DATA-1:0]                 D_o,
    output logic                                            dv_o
);

    import pt2272_pkg::*;

    logic    tick;
    pulse_t  pulse;  // Meter to classifier
    symbol_t sym;    // Classifier to assembler
    frame_t  frame;  // Assembler to checker

    osc_tick_gen #(.TICK_DIV(TICK_DIV)) osc_tick_gen_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .tick_o  (tick)
    );

    pulse_meter #(.ALPHA_TICKS(ALPHA_TICKS)) pulse_meter_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .tick_i  (tick),
        .cod_i   (cod_i),
        .pulse_o (pulse)
    );

    symbol_classifier #(.ALPHA_TICKS(ALPHA_TICKS)) symbol_classifier_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .pulse_i (pulse),
        .sym_o   (sym)
    );

    frame_assembler frame_assembler_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .sym_i   (sym),
        .frame_o (frame)
    );

    frame_checker frame_checker_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .frame_i (frame),
        .addr_i  (A_i),  // Local address pins
        .data_o  (D_o),
        .dv_o    (dv_o)
    );

endmodule

`default_nettype wire

/* tests/tb_pt2272_decoder.sv */
`default_nettype none

module tb_pt2272_decoder;

    import pt2272_pkg::*;

    localparam int TICK_DIV    = 4;
    localparam int ALPHA_TICKS = 4;
    localparam int ALPHA_CYC   = TICK_DIV * ALPHA_TICKS;  // Clock cycles per alpha
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_FRAMES  = 16;                       // Frames sent over the whole run
    localparam longint TIMEOUT = longint'(NUM_FRAMES * 600 + 400) * ALPHA_CYC * CLK_PERIOD;

    logic                     osc_clk;
    logic                     reset;
    logic                     cod;
    sym_code_t [0:NUM_ADDR-1] addr;      // Local address pins
    logic [NUM_DATA-1:0]      data_out;
    logic                     dv;

    logic [31:0]         lfsr_state;
    logic [NUM_DATA-1:0] exp_q[$];       // Expected D_o, one entry per pulse
    logic [NUM_DATA-1:0] exp_d;
    logic [NUM_DATA-1:0] last_data;      // D_o held between pulses
    frame_u              ref_hist;       // Model of the repeat history
    logic                ref_hist_vld;
    int                  exp_pulses;
    int                  dv_count;
    int                  value_errors;
    int                  pulse_errors;

    pt2272_decoder #(
        .TICK_DIV    (TICK_DIV),
        .ALPHA_TICKS (ALPHA_TICKS)
    ) pt2272_decoder_inst (
        .osc_clk (osc_clk),
        .reset   (reset),
        .cod_i   (cod),
        .A_i     (addr),
        .D_o     (data_out),
        .dv_o    (dv)
    );

    initial begin
        osc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) osc_clk = ~osc_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step per bit
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic sym_code_t rand_trit();
        logic [7:0] r;
        sym_code_t  t;
        r = rand_bits(2);
        case (r[1:0])
            2'd0: t = SYM_0;
            2'd1: t = SYM_1;
            default: t = SYM_F;  // F twice as likely
        endcase
        return t;
    endfunction

    function automatic sym_code_t other_trit(input sym_code_t t);
        sym_code_t o;
        case (t)
            SYM_0: o = SYM_1;
            SYM_1: o = SYM_F;
            default: o = SYM_0;
        endcase
        return o;
    endfunction

    // Given address, random binary data
    function automatic frame_u rand_frame(input sym_code_t [0:NUM_ADDR-1] a);
        frame_u     f;
        logic [7:0] r;
        f.fields.addr = a;
        for (int i = 0; i < NUM_DATA; i++) begin
            r = rand_bits(1);
            f.fields.data[i] = r[0] ? SYM_1 : SYM_0;
        end
        return f;
    endfunction

    // Expected response to one complete frame, {dv, data}
    function automatic logic [NUM_DATA:0] ref_decode(input frame_u cur, input frame_u prev,
                                                    input logic prev_vld,
                                                    input sym_code_t [0:NUM_ADDR-1] a);
        logic                hit;
        logic [NUM_DATA-1:0] d;
        hit = prev_vld && (cur == prev);  // Needs the same frame twice in a row
        for (int i = 0; i < NUM_ADDR; i++)
            if (cur.fields.addr[i] != a[i])
                hit = 1'b0;
        for (int i = 0; i < NUM_DATA; i++) begin
            case (cur.fields.data[i])
                SYM_0: d[i] = 1'b0;
                SYM_1: d[i] = 1'b1;
                default: begin
                    d[i] = 1'b0;
                    hit  = 1'b0;  // F is not a data value
                end
            endcase
        end
        return {hit, d};
    endfunction

    task automatic drive_level(input logic level, input int alphas);
        @(posedge osc_clk);
        cod <= level;
        repeat (alphas * ALPHA_CYC - 1) @(posedge osc_clk);
    endtask

    task automatic send_pulse(input int high_a, input int low_a);
        drive_level(1'b1, high_a);
        drive_level(1'b0, low_a);
    endtask

    task automatic send_symbol(input sym_code_t s);
        case (s)
            SYM_0: begin
                send_pulse(4, 12);
                send_pulse(4, 12);
            end
            SYM_1: begin
                send_pulse(12, 4);
                send_pulse(12, 4);
            end
            SYM_F: begin
                send_pulse(4, 12);
                send_pulse(12, 4);
            end
            default: send_pulse(4, 124);  // Sync
        endcase
    endtask

    // First nbits code bits then sync, model updated once the sync gap is out
    task automatic send_frame(input frame_u f, input int nbits);
        logic [NUM_DATA:0] r;
        for (int i = 0; i < nbits; i++)
            send_symbol(f.syms[i]);
        send_symbol(SYM_SYNC);
        if (nbits != NUM_SYMS) begin
            ref_hist_vld = 1'b0;  // Short frame breaks the chain
        end else begin
            r = ref_decode(f, ref_hist, ref_hist_vld, addr);
            if (r[NUM_DATA]) begin
                exp_q.push_back(r[NUM_DATA-1:0]);
                exp_pulses++;
            end
            ref_hist     = f;
            ref_hist_vld = 1'b1;
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge osc_clk) begin
        if (!reset) begin
            if (dv) begin
                dv_count++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected dv_o pulse at time %0t with D_o %b", $time, data_out);
                    pulse_errors++;
                    last_data = data_out;
                end else begin
                    exp_d = exp_q.pop_front();
                    if (data_out != exp_d) begin
                        $display("ERROR at %0t: D_o %b on dv_o, expected %b",
                                 $time, data_out, exp_d);
                        value_errors++;
                    end
                    last_data = exp_d;
                end
            end else if (data_out != last_data) begin
                $display("ERROR at %0t: D_o changed to %b without dv_o, expected %b",
                         $time, data_out, last_data);
                value_errors++;
                last_data = data_out;  // Avoid a cascade of reports
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired at %0t: %0d value errors, %0d pulse errors, %0d of %0d pulses",
                 $time, value_errors, pulse_errors, dv_count, exp_pulses);
        $display("Test failures found");
        $finish;
    end

    initial begin
        sym_code_t [0:NUM_ADDR-1] local_addr;
        frame_u                   m;
        frame_u                   p;
        frame_u                   q;
        logic [7:0]               r;
        int                       idx;
        lfsr_state   = 32'h977;
        exp_pulses   = 0;
        dv_count     = 0;
        value_errors = 0;
        pulse_errors = 0;
        last_data    = '0;  // D_o cleared by reset
        ref_hist     = '0;
        ref_hist_vld = 1'b0;
        for (int i = 0; i < NUM_ADDR; i++)
            local_addr[i] = rand_trit();
        cod   <= 1'b0;
        addr  <= local_addr;
        reset <= 1'b1;
        repeat (2) @(posedge osc_clk);
        reset <= 1'b0;

        // Idle after reset, then one frame three times for two pulses
        m = rand_frame(local_addr);
        repeat (3) send_frame(m, NUM_SYMS);

        // One address trit off
        p = m;
        r = rand_bits(3);
        idx = int'(r[2:0]);
        p.fields.addr[idx] = other_trit(p.fields.addr[idx]);
        repeat (2) send_frame(p, NUM_SYMS);

        // F in a data position
        p = rand_frame(local_addr);
        r = rand_bits(2);
        idx = int'(r[1:0]);
        p.fields.data[idx] = SYM_F;
        repeat (2) send_frame(p, NUM_SYMS);

        // Alternating frames, then the second one repeated
        p = rand_frame(local_addr);
        q = rand_frame(local_addr);
        q.fields.data[0] = (p.fields.data[0] == SYM_1) ? SYM_0 : SYM_1;
        send_frame(p, NUM_SYMS);
        send_frame(q, NUM_SYMS);
        send_frame(p, NUM_SYMS);
        send_frame(q, NUM_SYMS);
        send_frame(q, NUM_SYMS);

        // Short frame between two copies clears the history
        m = rand_frame(local_addr);
        send_frame(m, NUM_SYMS);
        send_frame(m, 7);
        send_frame(m, NUM_SYMS);
        send_frame(m, NUM_SYMS);

        send_pulse(4, 12);  // Rising edge closes the last sync
        while (exp_q.size() != 0)
            @(posedge osc_clk);
        repeat (4 * ALPHA_CYC) @(posedge osc_clk);  // Room for a stray pulse
        if (dv_count != exp_pulses) begin
            $display("Saw %0d dv_o pulses but expected %0d", dv_count, exp_pulses);
            pulse_errors++;
        end
        $display("Run complete: %0d value errors, %0d pulse errors, %0d of %0d pulses",
                 value_errors, pulse_errors, dv_count, exp_pulses);
        if (value_errors == 0 && pulse_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pt2272_decoder.f */
hw/pt2272_pkg.sv
hw/osc_tick_gen.sv
hw/pulse_meter.sv
hw/symbol_classifier.sv
hw/frame_assembler.sv
hw/frame_checker.sv
hw/pt2272_decoder.sv
tests/tb_pt2272_decoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pt2272_decoder
FILELIST  ?= pt2272_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
